//--- logic/mem_issuer.sv
`timescale 1ns/1ps

module mem_issuer (
  input  logic                                              clock,
  input  logic                                              reset,
  input  mshr_pkg::mshr_entry_t [mshr_pkg::MSHR_DEPTH-1:0]  queue,

  // memory bus
  input  mshr_pkg::mem_tag_t                                mem_response,
  output mshr_pkg::mem_req_t                                mem_req,

  // back to the table
  output logic                                              issue_accept,
  output mshr_pkg::mshr_idx_t                               issue_idx,
  output mshr_pkg::mem_tag_t                                issue_tag
);

  import mshr_pkg::*;

  mshr_idx_t   issue_ptr;
  mshr_entry_t head;
  logic        present;

  assign head = queue[issue_ptr];

  // strictly in order, the head waits until memory says yes
  assign present = head.valid && head.state == WAITING;

  always_comb begin
    mem_req.command = present ? head.command : BUS_NONE;
    mem_req.addr    = head.addr;
    mem_req.data    = head.data;
  end

  // a nonzero response is both the accept and the tag
  assign issue_accept = (mem_req.command != BUS_NONE) && (mem_response != '0);
  assign issue_idx    = issue_ptr;
  assign issue_tag    = mem_response;

  always_ff @(posedge clock) begin
    if (reset) begin
      issue_ptr <= '0;
    end else if (issue_accept) begin
      issue_ptr <= issue_ptr + 1'b1;
    end
  end

endmodule

//--- logic/mshr_pkg.sv
package mshr_pkg;

  // queue geometry
  localparam int MSHR_DEPTH = 8;
  localparam int IDX_WIDTH  = $clog2(MSHR_DEPTH);

  // one line address and one line of data
  localparam int ADDR_WIDTH = 64;
  localparam int DATA_WIDTH = 64;

  // memory transaction tag, zero means no transaction
  localparam int TAG_WIDTH = 4;

  typedef logic [IDX_WIDTH-1:0] mshr_idx_t;
  typedef logic [TAG_WIDTH-1:0] mem_tag_t;

  typedef enum logic [1:0] {
    BUS_NONE  = 2'h0,
    BUS_LOAD  = 2'h1,
    BUS_STORE = 2'h2
  } bus_command_t;

  // WAITING until memory accepts, INPROGRESS while load data is out
  typedef enum logic [1:0] {
    WAITING    = 2'h0,
    INPROGRESS = 2'h1,
    DONE       = 2'h2
  } entry_state_t;

  // miss from the cache, a fill or a dirty eviction
  typedef struct packed {
    logic [ADDR_WIDTH-1:0] addr;
    logic [DATA_WIDTH-1:0] data;
    bus_command_t          command;
  } miss_req_t;

  typedef struct packed {
    logic                  valid;
    entry_state_t          state;
    mem_tag_t              mem_tag;
    logic [ADDR_WIDTH-1:0] addr;
    logic [DATA_WIDTH-1:0] data;
    bus_command_t          command;
  } mshr_entry_t;

  // request on the memory bus
  typedef struct packed {
    bus_command_t          command;
    logic [ADDR_WIDTH-1:0] addr;
    logic [DATA_WIDTH-1:0] data;
  } mem_req_t;

  // returned line handed back to the cache
  typedef struct packed {
    logic [ADDR_WIDTH-1:0] addr;
    logic [DATA_WIDTH-1:0] data;
  } refill_t;

endpackage

//--- logic/mshr_table.sv
`timescale 1ns/1ps

module mshr_table (
  input  logic                                              clock,
  input  logic                                              reset,

  // cache side
  input  logic                                              miss_valid,
  input  mshr_pkg::miss_req_t                               miss_req,
  output logic                                              ready,
  output logic                                              mshr_empty,

  // from the issuer
  input  logic                                              issue_accept,
  input  mshr_pkg::mshr_idx_t                               issue_idx,
  input  mshr_pkg::mem_tag_t                                issue_tag,

  // memory return
  input  mshr_pkg::mem_tag_t                                mem_tag,
  input  logic [mshr_pkg::DATA_WIDTH-1:0]                   mem_data,

  // from the retire block
  input  logic                                              retire_free,
  input  mshr_pkg::mshr_idx_t                               retire_idx,

  output mshr_pkg::mshr_entry_t [mshr_pkg::MSHR_DEPTH-1:0]  queue
);

  import mshr_pkg::*;

  mshr_idx_t tail;
  logic      alloc;
  logic      any_valid;

  // only a free tail slot can take a new miss
  assign ready = !queue[tail].valid;
  assign alloc = miss_valid && ready;

  always_comb begin
    any_valid = 1'b0;
    for (int i = 0; i < MSHR_DEPTH; i++) begin
      any_valid = any_valid | queue[i].valid;
    end
    mshr_empty = !any_valid;
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < MSHR_DEPTH; i++) begin
        queue[i].valid   <= 1'b0;
        queue[i].state   <= WAITING;
        queue[i].mem_tag <= '0;
      end
      tail <= '0;
    end else begin
      if (alloc) begin
        queue[tail] <= '{valid:   1'b1,
                         state:   WAITING,
                         mem_tag: '0,
                         addr:    miss_req.addr,
                         data:    miss_req.data,
                         command: miss_req.command};
        tail <= tail + 1'b1;
      end

      // memory took the head request
      if (issue_accept) begin
        if (queue[issue_idx].command == BUS_LOAD) begin
          queue[issue_idx].state   <= INPROGRESS;
          queue[issue_idx].mem_tag <= issue_tag;
        end else begin
          // nothing comes back for a writeback
          queue[issue_idx].state <= DONE;
        end
      end

      // tagged data may return for any outstanding load
      if (mem_tag != '0) begin
        for (int i = 0; i < MSHR_DEPTH; i++) begin
          if (queue[i].valid && queue[i].state == INPROGRESS &&
              queue[i].mem_tag == mem_tag) begin
            queue[i].state <= DONE;
            queue[i].data  <= mem_data;
          end
        end
      end

      if (retire_free) begin
        queue[retire_idx].valid <= 1'b0;
      end
    end
  end

endmodule

//--- logic/mshr_top.sv
`timescale 1ns/1ps

module mshr_top (
  input  logic                             clock,
  input  logic                             reset,

  // cache miss side
  input  logic                             miss_valid,
  input  mshr_pkg::miss_req_t              miss_req,
  output logic                             ready,
  output logic                             mshr_empty,

  // memory bus
  input  mshr_pkg::mem_tag_t               mem_response,
  input  mshr_pkg::mem_tag_t               mem_tag,
  input  logic [mshr_pkg::DATA_WIDTH-1:0]  mem_data,
  output mshr_pkg::mem_req_t               mem_req,

  // refill to the cache
  output logic                             refill_valid,
  output mshr_pkg::refill_t                refill,
  input  logic                             refill_taken
);

  import mshr_pkg::*;

  mshr_entry_t [MSHR_DEPTH-1:0] queue;

  logic      issue_accept;
  mshr_idx_t issue_idx;
  mem_tag_t  issue_tag;

  logic      retire_free;
  mshr_idx_t retire_idx;

  mshr_table table_i (
    .clock        (clock),
    .reset        (reset),
    .miss_valid   (miss_valid),
    .miss_req     (miss_req),
    .ready        (ready),
    .mshr_empty   (mshr_empty),
    .issue_accept (issue_accept),
    .issue_idx    (issue_idx),
    .issue_tag    (issue_tag),
    .mem_tag      (mem_tag),
    .mem_data     (mem_data),
    .retire_free  (retire_free),
    .retire_idx   (retire_idx),
    .queue        (queue)
  );

  mem_issuer issuer_i (
    .clock        (clock),
    .reset        (reset),
    .queue        (queue),
    .mem_response (mem_response),
    .mem_req      (mem_req),
    .issue_accept (issue_accept),
    .issue_idx    (issue_idx),
    .issue_tag    (issue_tag)
  );

  refill_retire retire_i (
    .clock        (clock),
    .reset        (reset),
    .queue        (queue),
    .refill_taken (refill_taken),
    .refill_valid (refill_valid),
    .refill       (refill),
    .retire_free  (retire_free),
    .retire_idx   (retire_idx)
  );

endmodule

//--- logic/refill_retire.sv
`timescale 1ns/1ps

module refill_retire (
  input  logic                                              clock,
  input  logic                                              reset,
  input  mshr_pkg::mshr_entry_t [mshr_pkg::MSHR_DEPTH-1:0]  queue,

  // cache side
  input  logic                                              refill_taken,
  output logic                                              refill_valid,
  output mshr_pkg::refill_t                                 refill,

  // back to the table
  output logic                                              retire_free,
  output mshr_pkg::mshr_idx_t                               retire_idx
);

  import mshr_pkg::*;

  mshr_idx_t   wb_ptr;
  mshr_entry_t oldest;
  logic        oldest_done;

  assign oldest      = queue[wb_ptr];
  assign oldest_done = oldest.valid && oldest.state == DONE;

  // completed fills go back to the cache in allocation order
  assign refill_valid = oldest_done && oldest.command == BUS_LOAD;

  always_comb begin
    refill.addr = oldest.addr;
    refill.data = oldest.data;
  end

  // a fill waits for the cache, a writeback leaves right away
  assign retire_free = refill_valid ? refill_taken :
                       (oldest_done && oldest.command == BUS_STORE);
  assign retire_idx  = wb_ptr;

  always_ff @(posedge clock) begin
    if (reset) begin
      wb_ptr <= '0;
    end else if (retire_free) begin
      wb_ptr <= wb_ptr + 1'b1;
    end
  end

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the MSHR testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module mshr_tb -f sources.f \
  -Mdir obj_dir -o mshr_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/mshr_sim > sim.log 2>&1
run_status=$?
cat sim.log
if [ $run_status -ne 0 ]; then
  echo "simulation exited with status $run_status"
  exit 1
fi

if grep -qx "NO ERRORS" sim.log; then
  echo "simulation passed"
  exit 0
fi
echo "simulation failed, see sim.log"
exit 1

//--- sim/mshr_props.sv
`timescale 1ns/1ps

module mshr_props (
  input logic               clock,
  input logic               reset,
  input mshr_pkg::mem_req_t mem_req,
  input mshr_pkg::mem_tag_t mem_response,
  input logic               refill_valid,
  input logic               refill_taken
);

  import mshr_pkg::*;

  int refill_errors = 0;
  int bus_errors    = 0;
  int reset_errors  = 0;
  int failures;

  assign failures = refill_errors + bus_errors + reset_errors;

  // a refill waits for the cache
  refill_held: assert property (@(posedge clock) disable iff (reset)
    refill_valid && !refill_taken |=> refill_valid)
    else begin
      $error("refill_valid dropped before refill_taken");
      refill_errors++;
    end

  // head request must not move while memory says no
  bus_held: assert property (@(posedge clock) disable iff (reset)
    mem_req.command != BUS_NONE && mem_response == '0 |=>
      mem_req.command == $past(mem_req.command) && mem_req.addr == $past(mem_req.addr))
    else begin
      $error("mem_req changed while mem_response was zero");
      bus_errors++;
    end

  quiet_in_reset: assert property (@(posedge clock)
    reset && $past(reset) |-> mem_req.command == BUS_NONE && !refill_valid)
    else begin
      $error("command or refill seen during reset");
      reset_errors++;
    end

endmodule

bind mshr_top mshr_props props_i (.*);

//--- sim/mshr_tb.sv
`timescale 1ns/1ps

module mshr_tb;

  import mshr_pkg::*;

  localparam logic [DATA_WIDTH-1:0] PATTERN = 64'h5a5a_c3c3_0f0f_9696;
  localparam int TIMEOUT   = 200;
  localparam int W_READY   = 0;
  localparam int W_BUS     = 1;
  localparam int W_REFILL  = 2;
  localparam int W_EMPTY   = 3;
  localparam int W_PENDING = 4;

  logic                  clock = 1'b0;
  logic                  reset;
  logic                  miss_valid;
  miss_req_t             miss_req;
  logic                  ready;
  logic                  mshr_empty;
  mem_tag_t              mem_response = '0;
  mem_tag_t              mem_tag;
  logic [DATA_WIDTH-1:0] mem_data;
  mem_req_t              mem_req;
  logic                  refill_valid;
  refill_t               refill;
  logic                  refill_taken;

  // memory model state
  logic                  mem_allow;
  mem_tag_t              next_tag = 4'd1;
  mem_req_t              bus_seen = '0;
  mem_tag_t              pend_tag[$];
  logic [ADDR_WIDTH-1:0] pend_addr[$];
  int                    refill_cycles = 0;

  mshr_top UUT (.*);

  always #10 clock = ~clock;

  // bus as seen mid-cycle
  always @(negedge clock) begin
    bus_seen = mem_req;
  end

  // memory offers the next tag while allowed and queues accepted loads
  always @(posedge clock) begin
    if (refill_valid) begin
      refill_cycles++;
    end
    if (reset) begin
      mem_response <= '0;
    end else begin
      if (bus_seen.command != BUS_NONE && mem_response != '0) begin
        if (bus_seen.command == BUS_LOAD) begin
          pend_tag.push_back(mem_response);
          pend_addr.push_back(bus_seen.addr);
        end
        next_tag = (next_tag == 4'd15) ? 4'd1 : next_tag + 4'd1;
      end
      mem_response <= mem_allow ? next_tag : '0;
    end
  end

  task automatic stop_on_error(input string what);
    $display("%0t: %s", $time, what);
    $display("ERRORS FOUND");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_equal(input string name, input logic [63:0] actual,
                             input logic [63:0] expected);
    assert (actual === expected) else begin
      $display("[FAIL] %0t %s expected %0h actual %0h", $time, name, expected, actual);
      $display("ERRORS FOUND");
      $fatal(1, "check failed");
    end
  endtask

  task automatic wait_until(input int kind, input int goal, input string what);
    int   cycles;
    logic met;
    cycles = 0;
    met    = 1'b0;
    while (!met) begin
      @(negedge clock);
      case (kind)
        W_READY:  met = ready;
        W_BUS:    met = (mem_req.command != BUS_NONE);
        W_REFILL: met = refill_valid;
        W_EMPTY:  met = mshr_empty;
        default:  met = (pend_tag.size() >= goal);
      endcase
      cycles++;
      if (!met && cycles >= TIMEOUT) begin
        stop_on_error({"timed out waiting for ", what});
      end
    end
  endtask

  task automatic send_miss(input bus_command_t command, input logic [63:0] addr,
                           input logic [63:0] data);
    wait_until(W_READY, 0, "ready");
    @(posedge clock);
    miss_valid <= 1'b1;
    miss_req   <= '{addr: addr, data: data, command: command};
    @(posedge clock);
    miss_valid <= 1'b0;
  endtask

  task automatic return_data(input mem_tag_t tag, input logic [63:0] addr);
    @(posedge clock);
    mem_tag  <= tag;
    mem_data <= addr ^ PATTERN;
    @(posedge clock);
    mem_tag  <= '0;
  endtask

  // cache side takes one refill after checking it
  task automatic take_refill(input logic [63:0] addr);
    wait_until(W_REFILL, 0, "refill_valid");
    check_equal("refill.addr", refill.addr, addr);
    check_equal("refill.data", refill.data, addr ^ PATTERN);
    @(posedge clock);
    refill_taken <= 1'b1;
    @(posedge clock);
    refill_taken <= 1'b0;
  endtask

  task automatic reset_state_check();
    @(negedge clock);
    check_equal("mem_req.command", 64'(mem_req.command), 64'(BUS_NONE));
    check_equal("refill_valid", 64'(refill_valid), 64'd0);
    check_equal("ready", 64'(ready), 64'd1);
    check_equal("mshr_empty", 64'(mshr_empty), 64'd1);
  endtask

  task automatic single_line_fill();
    logic [63:0] addr;
    mem_tag_t    tag;
    addr = {$urandom(), $urandom()};
    send_miss(BUS_LOAD, addr, 64'd0);
    wait_until(W_BUS, 0, "a load on mem_req");
    check_equal("mem_req.command", 64'(mem_req.command), 64'(BUS_LOAD));
    check_equal("mem_req.addr", mem_req.addr, addr);
    wait_until(W_PENDING, 1, "memory to accept the load");
    tag = pend_tag.pop_front();
    void'(pend_addr.pop_front());
    return_data(tag, addr);
    take_refill(addr);
    @(negedge clock);
    check_equal("mshr_empty", 64'(mshr_empty), 64'd1);
  endtask

  task automatic eviction_writeback();
    logic [63:0] addr;
    logic [63:0] data;
    int          refills_before;
    addr = {$urandom(), $urandom()};
    data = {$urandom(), $urandom()};
    refills_before = refill_cycles;
    send_miss(BUS_STORE, addr, data);
    wait_until(W_BUS, 0, "a store on mem_req");
    check_equal("mem_req.command", 64'(mem_req.command), 64'(BUS_STORE));
    check_equal("mem_req.addr", mem_req.addr, addr);
    check_equal("mem_req.data", mem_req.data, data);
    wait_until(W_EMPTY, 0, "the store to retire");
    check_equal("refill_valid cycles", 64'(refill_cycles - refills_before), 64'd0);
  endtask

  task automatic full_queue_backpressure();
    @(posedge clock);
    mem_allow <= 1'b0;
    for (int i = 0; i < MSHR_DEPTH; i++) begin
      send_miss(BUS_STORE, 64'h1000 + 64'(i) * 64'h40, ~(64'h1000 + 64'(i) * 64'h40));
      @(negedge clock);
      // head stays on the bus the whole time
      check_equal("mem_req.command", 64'(mem_req.command), 64'(BUS_STORE));
      check_equal("mem_req.addr", mem_req.addr, 64'h1000);
      check_equal("mem_req.data", mem_req.data, ~64'h1000);
    end
    check_equal("ready", 64'(ready), 64'd0);
    @(posedge clock);
    mem_allow <= 1'b1;
    wait_until(W_EMPTY, 0, "the stores to drain");
  endtask

  task automatic out_of_order_returns();
    logic [63:0] addrs[4];
    logic [63:0] addr;
    mem_tag_t    tag;
    int          pick;
    for (int i = 0; i < 4; i++) begin
      addrs[i] = {$urandom(), $urandom()};
    end
    send_miss(BUS_LOAD, addrs[0], 64'd0);
    send_miss(BUS_LOAD, addrs[1], 64'd0);
    send_miss(BUS_STORE, 64'hbeef_0000, 64'h1234_5678);
    send_miss(BUS_LOAD, addrs[2], 64'd0);
    send_miss(BUS_LOAD, addrs[3], 64'd0);
    wait_until(W_PENDING, 4, "memory to accept four loads");
    while (pend_tag.size() > 0) begin
      pick = $urandom_range(pend_tag.size() - 1);
      tag  = pend_tag[pick];
      addr = pend_addr[pick];
      pend_tag.delete(pick);
      pend_addr.delete(pick);
      return_data(tag, addr);
      @(negedge clock);
    end
    // refills come back in allocation order, the store gives none
    for (int i = 0; i < 4; i++) begin
      take_refill(addrs[i]);
    end
    wait_until(W_EMPTY, 0, "the queue to empty");
    check_equal("refill_valid", 64'(refill_valid), 64'd0);
  endtask

  initial begin
    void'($urandom(11));
    reset        = 1'b1;
    miss_valid   = 1'b0;
    miss_req     = '0;
    mem_tag      = '0;
    mem_data     = '0;
    refill_taken = 1'b0;
    mem_allow    = 1'b1;
    repeat (2) @(posedge clock);
    reset <= 1'b0;
    reset_state_check();
    single_line_fill();
    eviction_writeback();
    full_queue_backpressure();
    out_of_order_returns();
    if (UUT.props_i.failures != 0) begin
      $display("%0t: bound assertions failed %0d times", $time, UUT.props_i.failures);
      $display("ERRORS FOUND");
      $fatal(1, "assertion failures");
    end else begin
      $display("NO ERRORS");
      $finish;
    end
  end

endmodule

//--- sources.f
logic/mshr_pkg.sv
logic/mshr_table.sv
logic/mem_issuer.sv
logic/refill_retire.sv
logic/mshr_top.sv
sim/mshr_props.sv
sim/mshr_tb.sv
